// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/rv_core_pkg.sv
      - source/inst_decode.sv
      - source/alu.sv
      - source/reg_file.sv
      - source/branch_unit.sv
      - source/fetch_control.sv
      - source/rv_core_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/rv_checker.sv
      - sim/tb_rv_core.sv

// File: rv_core.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/inst_decode.sv
source/alu.sv
source/reg_file.sv
source/branch_unit.sv
source/fetch_control.sv
source/rv_core_top.sv
sim/rv_checker.sv
sim/tb_rv_core.sv

// File: sim/rv_checker.sv
// retire and status checker
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ar_valid,
    input  logic                      ar_ready,
    input  logic [2:0]                ar_prot,
    input  logic                      retire_valid,
    input  logic [`RV_XLEN-1:0]       retire_pc,
    input  logic                      retire_we,
    input  logic [`RV_REG_ADDR_W-1:0] retire_rd,
    input  logic [`RV_XLEN-1:0]       retire_wdata,
    input  logic                      halted,
    input  logic                      fetch_error
);
    localparam logic [2:0] EXP_PROT = 3'b100;  // instruction access

    logic [`RV_XLEN-1:0]       exp_pc [$];
    logic                      exp_we [$];
    logic [`RV_REG_ADDR_W-1:0] exp_rd [$];
    logic [`RV_XLEN-1:0]       exp_wdata [$];

    logic [31:0] test_name;  // four ascii chars
    logic        active = 1'b0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    task automatic begin_test(input logic [31:0] name);
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_wdata.delete();
        test_name   = name;
        test_errors = 0;
        active      = 1'b1;
    endtask

    task automatic add_record(input logic [31:0] pc, input logic we,
                              input logic [4:0] rd, input logic [31:0] wdata);
        exp_pc.push_back(pc);
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_wdata.push_back(wdata);
    endtask

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
        test_errors++;
    endtask

    // expected records are consumed in retire order
    always @(posedge clk) begin
        logic [31:0] pc;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] wdata;
        if (!reset && active && retire_valid) begin
            if (exp_pc.size() == 0) begin
                $display("Error [%s]: extra retire at pc %h after the last expected one",
                         test_name, retire_pc);
                test_errors++;
            end else begin
                pc    = exp_pc.pop_front();
                we    = exp_we.pop_front();
                rd    = exp_rd.pop_front();
                wdata = exp_wdata.pop_front();
                if (retire_pc !== pc) report_value("retire_pc", pc, retire_pc);
                if (retire_we !== we) report_value("retire_we", 32'(we), 32'(retire_we));
                if (we && retire_rd !== rd) report_value("retire_rd", 32'(rd), 32'(retire_rd));
                if (we && retire_wdata !== wdata) begin
                    report_value("retire_wdata", wdata, retire_wdata);
                end
            end
        end
    end

    // every fetch request is marked as an instruction access
    always @(posedge clk) begin
        if (!reset && active && ar_valid && ar_ready && ar_prot !== EXP_PROT) begin
            report_value("ar_prot", 32'(EXP_PROT), 32'(ar_prot));
        end
    end

    // end_kind 1 is a halt on EBREAK, 2 a fetch error
    task automatic finish_test(input int end_kind, input bit timed_out);
        if (timed_out) begin
            $display("Error [%s]: timed out waiting for the core to halt", test_name);
            test_errors++;
        end else begin
            if (!halted) begin
                $display("Error [%s]: the core did not halt", test_name);
                test_errors++;
            end
            if (fetch_error !== (end_kind == 2)) begin
                report_value("fetch_error", 32'(end_kind == 2), 32'(fetch_error));
            end
        end
        if (exp_pc.size() != 0) begin
            $display("Error [%s]: %0d expected retires never happened", test_name,
                     exp_pc.size());
            test_errors++;
        end
        active = 1'b0;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

endmodule

`default_nettype wire

// File: sim/rv_core_tests.txt
// test: name(ascii) prog_words slverr_addr(0=none) records end(1=halt 2=fetch error)
// then program words from 8000_0000, then records: pc we rd wdata
616c755f 9 00000000 9 1
ffb00093 00300113 402081b3 4020d233 0020a2b3 0020b333 01c0d393 0f00c413 00100073
80000000 1 01 fffffffb
80000004 1 02 00000003
80000008 1 03 fffffff8
8000000c 1 04 ffffffff
80000010 1 05 00000001
80000014 1 06 00000000
80000018 1 07 0000000f
8000001c 1 08 ffffff0b
80000020 0 00 00000000
75706a6c 9 00000000 8 1
123450b7 00001117 008001ef 00100493 00700013 00000233 00000297 00928367 00100073
80000000 1 01 12345000
80000004 1 02 80001004
80000008 1 03 8000000c
80000010 0 00 00000000
80000014 1 04 00000000
80000018 1 05 80000018
8000001c 1 06 80000020
80000020 0 00 00000000
62726368 21 00000000 15 1
fff00093 00100113 00208463 00209463 00100493 0020c463 00100493 0020d463
0020e463 0020f463 00100493 00108463 00100493 00211463 00114463 00115463
00100493 00116463 00100493 00117463 00100073
80000000 1 01 ffffffff
80000004 1 02 00000001
80000008 0 00 00000000
8000000c 0 00 00000000
80000014 0 00 00000000
8000001c 0 00 00000000
80000020 0 00 00000000
80000024 0 00 00000000
8000002c 0 00 00000000
80000034 0 00 00000000
80000038 0 00 00000000
8000003c 0 00 00000000
80000044 0 00 00000000
8000004c 0 00 00000000
80000050 0 00 00000000
73657272 2 80000004 1 2
00500093 00600113
80000000 1 01 00000005
00000000

// File: sim/tb_rv_core.sv
// rv32i core testbench
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module tb_rv_core;
    localparam int MEM_WORDS    = 64;
    localparam int DATA_WORDS   = 1024;
    localparam int HALT_TIMEOUT = 2000;
    localparam logic [31:0] SEED = 32'h9148_afc4;

    logic        clk;
    logic        reset = 1'b1;
    logic        ar_valid;
    logic        ar_ready = 1'b0;
    logic [31:0] ar_addr;
    logic [2:0]  ar_prot;
    logic        r_valid = 1'b0;
    logic        r_ready;
    logic [31:0] r_data = '0;
    logic [1:0]  r_resp = 2'b00;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic        halted;
    logic        fetch_error;

    logic [31:0] test_data [DATA_WORDS];
    logic [31:0] prog_mem [MEM_WORDS];
    logic [1:0]  delays [256];
    logic [7:0]  delay_idx = '0;
    logic        err_en = 1'b0;
    logic [31:0] err_addr = '0;

    // memory side state
    logic        busy = 1'b0;
    logic [31:0] req_addr = '0;
    int          ar_wait = 0;
    int          r_wait = 0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    rv_core_top uut (
        .clk(clk), .reset(reset),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_prot(ar_prot),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_resp(r_resp),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_rd(retire_rd), .retire_wdata(retire_wdata),
        .halted(halted), .fetch_error(fetch_error)
    );

    rv_checker chk (
        .clk(clk), .reset(reset),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_prot(ar_prot),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_rd(retire_rd), .retire_wdata(retire_wdata),
        .halted(halted), .fetch_error(fetch_error)
    );

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `RV_RESET_PC;
        if (offset < MEM_WORDS * 4) return prog_mem[offset[31:2]];
        return fill_word(addr);
    endfunction

    // count fields in the test file are written as decimal digits
    function automatic int decimal_count(input logic [31:0] field);
        int value;
        value = 0;
        for (int d = 7; d >= 0; d--) value = value * 10 + int'(field[d*4 +: 4]);
        return value;
    endfunction

    // AXI4-Lite read slave with 0 to 3 cycles of delay on each channel
    always @(posedge clk) begin
        if (reset) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            busy     <= 1'b0;
            ar_wait  <= delays[delay_idx];
            delay_idx <= delay_idx + 1;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_ready  <= 1'b0;
                busy      <= 1'b1;
                req_addr  <= ar_addr;
                r_wait    <= delays[delay_idx];
                delay_idx <= delay_idx + 1;
            end else if (ar_valid && !busy) begin
                if (ar_wait == 0) ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (r_valid && r_ready) begin
                r_valid   <= 1'b0;
                busy      <= 1'b0;
                ar_wait   <= delays[delay_idx];
                delay_idx <= delay_idx + 1;
            end else if (busy && !r_valid) begin
                if (r_wait == 0) begin
                    r_valid <= 1'b1;
                    r_data  <= fetch_word(req_addr);
                    r_resp  <= (err_en && req_addr == err_addr) ? 2'b10 : 2'b00;  // SLVERR
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    initial begin
        int          ptr;
        int          n_prog;
        int          n_exp;
        int          end_kind;
        int          cycles;
        int          tests_run;
        logic [31:0] name;
        bit          timed_out;
        void'($urandom(SEED));
        for (int k = 0; k < 256; k++) delays[k] = 2'($urandom % 4);
        for (int k = 0; k < DATA_WORDS; k++) test_data[k] = '0;
        $readmemh("sim/rv_core_tests.txt", test_data);
        ptr = 0;
        tests_run = 0;
        while (ptr + 5 < DATA_WORDS && test_data[ptr] != '0) begin
            name     = test_data[ptr];
            n_prog   = decimal_count(test_data[ptr + 1]);
            err_addr = test_data[ptr + 2];
            n_exp    = decimal_count(test_data[ptr + 3]);
            end_kind = test_data[ptr + 4];
            ptr += 5;
            @(posedge clk);
            reset  <= 1'b1;
            err_en = (err_addr != '0);  // zero means every fetch answers OKAY
            for (int k = 0; k < MEM_WORDS; k++) begin
                prog_mem[k] = fill_word(`RV_RESET_PC + 32'(k * 4));
            end
            for (int k = 0; k < n_prog; k++) prog_mem[k] = test_data[ptr + k];
            ptr += n_prog;
            chk.begin_test(name);
            for (int k = 0; k < n_exp; k++) begin
                chk.add_record(test_data[ptr], test_data[ptr + 1][0],
                               test_data[ptr + 2][4:0], test_data[ptr + 3]);
                ptr += 4;
            end
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            cycles = 0;
            @(posedge clk);
            while (!(halted || fetch_error) && cycles < HALT_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            timed_out = !(halted || fetch_error);
            chk.finish_test(end_kind, timed_out);
            tests_run++;
        end
        $display("tests run %0d, passed %0d, failed %0d", tests_run, chk.tests_passed,
                 chk.tests_failed);
        if (chk.tests_failed == 0 && tests_run > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/alu.sv
// 32-bit integer ALU
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module alu (
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    input  rv_core_pkg::alu_op_e op,
    output logic [`RV_XLEN-1:0]  result
);
    localparam int MSB = `RV_XLEN - 1;

    logic               sub;
    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN-1:0] sum;
    logic               overflow;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [4:0]         shamt;

    // compares reuse the subtract path
    assign sub = (op == rv_core_pkg::SUB) || (op == rv_core_pkg::SLT) ||
                 (op == rv_core_pkg::SLTU);
    assign b_eff = b ^ {`RV_XLEN{sub}};
    assign sum   = a + b_eff + {{MSB{1'b0}}, sub};

    assign overflow  = (a[MSB] == b_eff[MSB]) && (sum[MSB] != a[MSB]);
    assign lt_signed = sum[MSB] ^ overflow;

    // differing msbs decide directly, otherwise the difference sign
    assign lt_unsigned = (a[MSB] == b[MSB]) ? sum[MSB] : b[MSB];

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::ADD,
            rv_core_pkg::SUB:  result = sum;
            rv_core_pkg::AND:  result = a & b;
            rv_core_pkg::OR:   result = a | b;
            rv_core_pkg::XOR:  result = a ^ b;
            rv_core_pkg::SLT:  result = {{MSB{1'b0}}, lt_signed};
            rv_core_pkg::SLTU: result = {{MSB{1'b0}}, lt_unsigned};
            rv_core_pkg::SLL:  result = a << shamt;
            rv_core_pkg::SRL:  result = a >> shamt;
            rv_core_pkg::SRA:  result = $unsigned($signed(a) >>> shamt);
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/branch_unit.sv
// branch resolution and next pc
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module branch_unit (
    input  logic [`RV_XLEN-1:0]     pc,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    input  logic [`RV_XLEN-1:0]     alu_result,
    input  rv_core_pkg::jump_kind_e jump_kind,
    input  rv_isa_pkg::branch_f3_e  branch_f3,
    output logic [`RV_XLEN-1:0]     next_pc,
    output logic [`RV_XLEN-1:0]     link
);
    logic taken;

    assign link = pc + `RV_INST_BYTES;

    always_comb begin
        case (branch_f3)
            rv_isa_pkg::BEQ:  taken = (rs1_data == rs2_data);
            rv_isa_pkg::BNE:  taken = (rs1_data != rs2_data);
            rv_isa_pkg::BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_isa_pkg::BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv_isa_pkg::BLTU: taken = (rs1_data < rs2_data);
            rv_isa_pkg::BGEU: taken = (rs1_data >= rs2_data);
            default:          taken = 1'b0;  // reserved funct3
        endcase
    end

    always_comb begin
        case (jump_kind)
            rv_core_pkg::JAL:    next_pc = alu_result;
            rv_core_pkg::JALR:   next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
            rv_core_pkg::BRANCH: next_pc = taken ? alu_result : link;
            default:             next_pc = link;
        endcase
    end

endmodule

`default_nettype wire

// File: source/fetch_control.sv
// fetch and sequencing FSM
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module fetch_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                ar_ready,
    output logic                ar_valid,
    output logic [`RV_XLEN-1:0] ar_addr,
    output logic [2:0]          ar_prot,
    input  logic                r_valid,
    input  logic [`RV_XLEN-1:0] r_data,
    input  logic [1:0]          r_resp,
    output logic                r_ready,
    input  logic [`RV_XLEN-1:0] next_pc,
    input  logic                is_ebreak,
    output logic [`RV_XLEN-1:0] inst,
    output logic [`RV_XLEN-1:0] pc,
    output logic                exec_en,
    output logic                retire_valid,
    output logic                halted,
    output logic                fetch_error
);
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [2:0] PROT_INSN = 3'b100;  // instruction, secure, unprivileged

    rv_core_pkg::ctrl_state_e state;
    logic [`RV_XLEN-1:0]      pc_q;
    logic [`RV_XLEN-1:0]      inst_q;
    logic                     error_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rv_core_pkg::ADDR;
            pc_q    <= `RV_RESET_PC;
            error_q <= 1'b0;
        end else begin
            case (state)
                rv_core_pkg::ADDR: begin
                    if (ar_ready) begin
                        state <= rv_core_pkg::DATA;
                    end
                end
                rv_core_pkg::DATA: begin
                    if (r_valid && r_resp != RESP_OKAY) begin
                        error_q <= 1'b1;  // bad fetch, no retire
                        state   <= rv_core_pkg::HALT;
                    end else if (r_valid) begin
                        state <= rv_core_pkg::EXEC;
                    end
                end
                rv_core_pkg::EXEC: begin
                    pc_q  <= next_pc;
                    state <= is_ebreak ? rv_core_pkg::HALT : rv_core_pkg::ADDR;
                end
                default: ;  // stays halted until reset
            endcase
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (state == rv_core_pkg::DATA && r_valid) begin
            inst_q <= r_data;
        end
    end

    assign ar_valid = (state == rv_core_pkg::ADDR);
    assign ar_addr  = pc_q;
    assign ar_prot  = PROT_INSN;
    assign r_ready  = (state == rv_core_pkg::DATA);  // always accepts in DATA

    assign inst    = inst_q;
    assign pc      = pc_q;
    assign exec_en = (state == rv_core_pkg::EXEC);

    assign retire_valid = exec_en;
    assign halted       = (state == rv_core_pkg::HALT);
    assign fetch_error  = error_q;

    // AXI rule, a stalled request keeps its address
    ar_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr)
    );

    // targets from the branch unit must stay on word boundaries
    ar_addr_aligned: assert property (
        @(posedge clk) disable iff (reset)
        ar_valid |-> ar_addr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: source/inst_decode.sv
// rv32i instruction decoder
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module inst_decode (
    input  logic [`RV_XLEN-1:0]       inst,
    output logic [`RV_REG_ADDR_W-1:0] rs1,
    output logic [`RV_REG_ADDR_W-1:0] rs2,
    output logic [`RV_REG_ADDR_W-1:0] rd,
    output logic [`RV_XLEN-1:0]       imm,
    output rv_core_pkg::alu_op_e      alu_op,
    output logic                      a_sel_pc,
    output logic                      a_zero,
    output logic                      b_imm,
    output rv_core_pkg::jump_kind_e   jump_kind,
    output rv_isa_pkg::branch_f3_e    branch_f3,
    output logic                      rd_we,
    output logic                      is_ebreak
);
    localparam logic [`RV_XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    rv_isa_pkg::inst_word_u word;
    logic [`RV_XLEN-1:0]    imm_i;
    logic [`RV_XLEN-1:0]    imm_b;
    logic [`RV_XLEN-1:0]    imm_u;
    logic [`RV_XLEN-1:0]    imm_j;
    rv_core_pkg::alu_op_e   arith_op;

    assign word = inst;

    assign rs1 = word.r.rs1;
    assign rs2 = word.r.rs2;
    assign rd  = word.r.rd;
    assign branch_f3 = rv_isa_pkg::branch_f3_e'(word.b.funct3);

    assign imm_i = {{20{word.i.imm_11_0[11]}}, word.i.imm_11_0};
    assign imm_b = {{20{word.b.imm_12}}, word.b.imm_11, word.b.imm_10_5, word.b.imm_4_1, 1'b0};
    assign imm_u = {word.u.imm_31_12, 12'b0};
    assign imm_j = {{12{word.j.imm_20}}, word.j.imm_19_12, word.j.imm_11,
                    word.j.imm_10_1, 1'b0};

    // funct3/funct7 to alu op, shared by OP and OP_IMM
    always_comb begin
        case (word.r.funct3)
            3'b000: begin
                if (word.r.opcode == rv_isa_pkg::OP && word.r.funct7[5]) begin
                    arith_op = rv_core_pkg::SUB;  // register form only
                end else begin
                    arith_op = rv_core_pkg::ADD;
                end
            end
            3'b001:  arith_op = rv_core_pkg::SLL;
            3'b010:  arith_op = rv_core_pkg::SLT;
            3'b011:  arith_op = rv_core_pkg::SLTU;
            3'b100:  arith_op = rv_core_pkg::XOR;
            3'b101:  arith_op = word.r.funct7[5] ? rv_core_pkg::SRA : rv_core_pkg::SRL;
            3'b110:  arith_op = rv_core_pkg::OR;
            default: arith_op = rv_core_pkg::AND;
        endcase
    end

    always_comb begin
        imm       = '0;
        alu_op    = rv_core_pkg::ADD;
        a_sel_pc  = 1'b0;
        a_zero    = 1'b0;
        b_imm     = 1'b0;
        jump_kind = rv_core_pkg::NONE;
        rd_we     = 1'b0;
        is_ebreak = 1'b0;
        case (word.r.opcode)
            rv_isa_pkg::OP: begin
                alu_op = arith_op;
                rd_we  = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                imm    = imm_i;
                alu_op = arith_op;
                b_imm  = 1'b1;
                rd_we  = 1'b1;
            end
            rv_isa_pkg::LUI: begin
                imm    = imm_u;
                a_zero = 1'b1;  // 0 + imm
                b_imm  = 1'b1;
                rd_we  = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                imm      = imm_u;
                a_sel_pc = 1'b1;
                b_imm    = 1'b1;
                rd_we    = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                imm       = imm_j;
                a_sel_pc  = 1'b1;  // alu forms the target
                b_imm     = 1'b1;
                jump_kind = rv_core_pkg::JAL;
                rd_we     = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                imm       = imm_i;
                b_imm     = 1'b1;
                jump_kind = rv_core_pkg::JALR;
                rd_we     = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                imm       = imm_b;
                a_sel_pc  = 1'b1;
                b_imm     = 1'b1;
                jump_kind = rv_core_pkg::BRANCH;
            end
            rv_isa_pkg::SYSTEM: begin
                is_ebreak = (word.raw == EBREAK_WORD);
            end
            default: ;  // retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
// integer register file
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      we,
    input  logic [`RV_REG_ADDR_W-1:0] waddr,
    input  logic [`RV_REG_ADDR_W-1:0] raddr1,
    input  logic [`RV_REG_ADDR_W-1:0] raddr2,
    input  logic [`RV_XLEN-1:0]       wdata,
    output logic [`RV_XLEN-1:0]       rdata1,
    output logic [`RV_XLEN-1:0]       rdata2
);
    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;  // x0 never written
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/rv_core_pkg.sv
// core microarchitecture types
`default_nettype none

package rv_core_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        BRANCH,
        JAL,
        JALR
    } jump_kind_e;

    // one instruction per pass through ADDR, DATA, EXEC
    typedef enum logic [1:0] {
        ADDR,
        DATA,
        EXEC,
        HALT
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/rv_core_top.sv
// rv32i core top level
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core_top (
    input  logic                      clk,
    input  logic                      reset,
    // AXI4-Lite instruction read
    output logic                      ar_valid,
    input  logic                      ar_ready,
    output logic [`RV_XLEN-1:0]       ar_addr,
    output logic [2:0]                ar_prot,
    input  logic                      r_valid,
    output logic                      r_ready,
    input  logic [`RV_XLEN-1:0]       r_data,
    input  logic [1:0]                r_resp,
    // retire and status
    output logic                      retire_valid,
    output logic [`RV_XLEN-1:0]       retire_pc,
    output logic                      retire_we,
    output logic [`RV_REG_ADDR_W-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]       retire_wdata,
    output logic                      halted,
    output logic                      fetch_error
);
    logic [`RV_XLEN-1:0]       inst;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       next_pc;
    logic                      exec_en;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       imm;
    rv_core_pkg::alu_op_e      alu_op;
    logic                      a_sel_pc;
    logic                      a_zero;
    logic                      b_imm;
    rv_core_pkg::jump_kind_e   jump_kind;
    rv_isa_pkg::branch_f3_e    branch_f3;
    logic                      rd_we;
    logic                      is_ebreak;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       alu_a;
    logic [`RV_XLEN-1:0]       alu_b;
    logic [`RV_XLEN-1:0]       alu_result;
    logic [`RV_XLEN-1:0]       link;
    logic [`RV_XLEN-1:0]       wdata;
    logic                      rf_we;

    fetch_control u_fetch (
        .clk          (clk),
        .reset        (reset),
        .ar_ready     (ar_ready),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .ar_prot      (ar_prot),
        .r_valid      (r_valid),
        .r_data       (r_data),
        .r_resp       (r_resp),
        .r_ready      (r_ready),
        .next_pc      (next_pc),
        .is_ebreak    (is_ebreak),
        .inst         (inst),
        .pc           (pc),
        .exec_en      (exec_en),
        .retire_valid (retire_valid),
        .halted       (halted),
        .fetch_error  (fetch_error)
    );

    inst_decode u_decode (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .a_sel_pc  (a_sel_pc),
        .a_zero    (a_zero),
        .b_imm     (b_imm),
        .jump_kind (jump_kind),
        .branch_f3 (branch_f3),
        .rd_we     (rd_we),
        .is_ebreak (is_ebreak)
    );

    assign rf_we = rd_we & exec_en;  // write on the edge ending EXEC

    reg_file u_regs (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // operand selects, LUI takes zero on a
    assign alu_a = a_zero ? '0 : (a_sel_pc ? pc : rs1_data);
    assign alu_b = b_imm ? imm : rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    branch_unit u_branch (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .jump_kind  (jump_kind),
        .branch_f3  (branch_f3),
        .next_pc    (next_pc),
        .link       (link)
    );

    // jumps write the return address
    assign wdata = (jump_kind == rv_core_pkg::JAL || jump_kind == rv_core_pkg::JALR) ?
                   link : alu_result;

    assign retire_pc    = pc;
    assign retire_we    = rf_we && (rd != '0);
    assign retire_rd    = rd;
    assign retire_wdata = wdata;

endmodule

`default_nettype wire

// File: source/rv_defines.svh
// rv32i core parameters
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

// pc step for sequential flow
`define RV_INST_BYTES 4

`endif

// File: source/rv_isa_pkg.sv
// rv32i instruction encoding
`default_nettype none
`include "rv_defines.svh"

package rv_isa_pkg;

    // major opcodes still handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]               imm_11_0;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                imm_11_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [4:0]                imm_4_0;
        logic [6:0]                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                      imm_12;
        logic [5:0]                imm_10_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [3:0]                imm_4_1;
        logic                      imm_11;
        logic [6:0]                opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]               imm_31_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                      imm_20;
        logic [9:0]                imm_10_1;
        logic                      imm_11;
        logic [7:0]                imm_19_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } j_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        logic [`RV_XLEN-1:0] raw;
        r_fmt_t              r;
        i_fmt_t              i;
        s_fmt_t              s;
        b_fmt_t              b;
        u_fmt_t              u;
        j_fmt_t              j;
    } inst_word_u;

endpackage

`default_nettype wire
